// ==== mem_pkg.sv ====
// Shared widths, request type and memory word view for the memory subsystem
package mem_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int unsigned DATA_W     = 64;
    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned BE_W       = DATA_W / 8;
    localparam int unsigned BYTE_OFF_W = $clog2(BE_W);

    // Instruction, data and uncached bypass
    localparam int unsigned NUM_PORTS  = 3;
    localparam int unsigned PORT_IDX_W = $clog2(NUM_PORTS);

    // ----------------------------------------
    // Request as held in the port queues
    // ----------------------------------------
    // addr is a word address, the byte offset is already stripped
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
    } mem_req_t;

    // ----------------------------------------
    // Memory word
    // ----------------------------------------
    // Read back as one word, merged on writes byte by byte
    typedef union packed {
        logic [DATA_W-1:0]     word;
        logic [BE_W-1:0][7:0]  bytes;
    } mem_word_u;

endpackage

// ==== mem_port_if.sv ====
// Link between one request queue and the memory arbiter, request and response side
`timescale 1ns/1ps

interface mem_port_if;

    // Head of queue, valid whenever the queue is not empty
    logic                            valid;
    mem_pkg::mem_req_t               req;

    // Removes the head entry in the issue cycle
    logic                            pop;

    // Response routed back by the arbiter
    logic                            rsp_valid;
    logic [mem_pkg::DATA_W-1:0]      rsp_rdata;

    modport queue (
        output valid,
        output req,
        input  pop,
        input  rsp_valid,
        input  rsp_rdata
    );

    modport arbiter (
        input  valid,
        input  req,
        output pop,
        output rsp_valid,
        output rsp_rdata
    );

endinterface

// ==== ingress_ctrl.sv ====
// Request ingress: packs requests for the queues, runs the mailbox flush and returns credits
`timescale 1ns/1ps

module ingress_ctrl #(
    parameter int unsigned                QUEUE_DEPTH   = 4,
    parameter logic [mem_pkg::ADDR_W-1:0] TOHOST_ADDR   = 32'h0000_1000,
    parameter logic [mem_pkg::ADDR_W-1:0] FROMHOST_ADDR = 32'h0000_1040
) (
    input  logic                                                  clk_i,
    input  logic                                                  rst_ni,
    input  logic [mem_pkg::NUM_PORTS-1:0]                         req_valid_i,
    input  logic [mem_pkg::NUM_PORTS-1:0]                         req_we_i,
    input  logic [mem_pkg::NUM_PORTS-1:0][mem_pkg::ADDR_W-1:0]    req_addr_i,
    input  logic [mem_pkg::NUM_PORTS-1:0][mem_pkg::DATA_W-1:0]    req_wdata_i,
    input  logic [mem_pkg::NUM_PORTS-1:0][mem_pkg::BE_W-1:0]      req_be_i,
    input  logic                                                  flush_req_i,
    input  logic [mem_pkg::NUM_PORTS-1:0]                         freed_i,
    input  logic                                                  drained_i,
    output logic [mem_pkg::NUM_PORTS-1:0]                         push_o,
    output mem_pkg::mem_req_t [mem_pkg::NUM_PORTS-1:0]            push_req_o,
    output logic [mem_pkg::NUM_PORTS-1:0]                         credit_o,
    output logic                                                  flushing_o
);

    // Enough to hold every credit of one port
    localparam int unsigned PEND_W = $clog2(QUEUE_DEPTH + 1);

    logic                                         mbox_hit;
    logic                                         flush_clr;
    logic                                         flushing_d, flushing_q;
    logic [mem_pkg::NUM_PORTS-1:0]                credit_q;
    logic [mem_pkg::NUM_PORTS-1:0][PEND_W-1:0]    pend_q;

    // ----------------------------------------
    // Request packing
    // ----------------------------------------
    // Credits guarantee room, so every valid request is pushed right away
    assign push_o = req_valid_i;

    for (genvar p = 0; p < mem_pkg::NUM_PORTS; p++) begin : g_pack
        assign push_req_o[p].we    = req_we_i[p];
        assign push_req_o[p].addr  = {{mem_pkg::BYTE_OFF_W{1'b0}},
                                      req_addr_i[p][mem_pkg::ADDR_W-1:mem_pkg::BYTE_OFF_W]};
        assign push_req_o[p].wdata = req_wdata_i[p];
        assign push_req_o[p].be    = req_be_i[p];
    end

    // ----------------------------------------
    // Mailbox detection and flush state
    // ----------------------------------------
    always_comb begin
        mbox_hit = 1'b0;
        for (int p = 0; p < mem_pkg::NUM_PORTS; p++) begin
            if (req_valid_i[p] && req_we_i[p] &&
                (req_addr_i[p] == TOHOST_ADDR || req_addr_i[p] == FROMHOST_ADDR)) begin
                mbox_hit = 1'b1;
            end
        end
    end

    // A request entering this cycle is not yet visible in drained
    assign flush_clr  = flushing_q & drained_i & ~(|req_valid_i);
    assign flushing_d = flush_req_i | mbox_hit | (flushing_q & ~flush_clr);

    // ----------------------------------------
    // Credit return
    // ----------------------------------------
    // Gated on the next flush state so no credit leaves while flushing_o is high
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            flushing_q <= 1'b0;
            credit_q   <= '0;
            pend_q     <= '0;
        end else begin
            flushing_q <= flushing_d;
            for (int p = 0; p < mem_pkg::NUM_PORTS; p++) begin
                if (flushing_d) begin
                    credit_q[p] <= 1'b0;
                    if (freed_i[p]) begin
                        pend_q[p] <= pend_q[p] + PEND_W'(1);
                    end
                end else if (pend_q[p] != '0) begin
                    // Drain the backlog one per cycle, a new free takes the released slot
                    credit_q[p] <= 1'b1;
                    if (!freed_i[p]) begin
                        pend_q[p] <= pend_q[p] - PEND_W'(1);
                    end
                end else begin
                    credit_q[p] <= freed_i[p];
                end
            end
        end
    end

    assign credit_o   = credit_q;
    assign flushing_o = flushing_q;

endmodule

// ==== port_queue.sv ====
// Request FIFO for one port, presents its head to the arbiter and reports freed slots
`timescale 1ns/1ps

module port_queue #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         push_i,
    input  mem_pkg::mem_req_t            push_req_i,
    output logic                         freed_o,
    mem_port_if.queue                    port,
    output logic                         rsp_valid_o,
    output logic [mem_pkg::DATA_W-1:0]   rsp_rdata_o
);

    localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

    mem_pkg::mem_req_t    entries [QUEUE_DEPTH];
    logic [PTR_W-1:0]     wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0]     count_q;

    // Depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            entries[wr_ptr_q] <= push_req_i;
        end
    end

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (port.pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(port.pop);
        end
    end

    assign port.valid = (count_q != '0);
    assign port.req   = entries[rd_ptr_q];

    // A pop frees its slot in the same cycle
    assign freed_o = port.pop;

    assign rsp_valid_o = port.rsp_valid;
    assign rsp_rdata_o = port.rsp_rdata;

endmodule

// ==== mem_arbiter.sv ====
// Round-robin issue from the port queues to the shared memory, with response routing
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    mem_port_if.arbiter                   ports [mem_pkg::NUM_PORTS],
    output mem_pkg::mem_req_t             mem_req_o,
    output logic                          mem_en_o,
    input  logic [mem_pkg::DATA_W-1:0]    mem_rdata_i,
    output logic                          drained_o
);

    logic [mem_pkg::NUM_PORTS-1:0]                 valid_vec;
    mem_pkg::mem_req_t [mem_pkg::NUM_PORTS-1:0]    req_vec;

    logic                                          grant_valid;
    logic [mem_pkg::PORT_IDX_W-1:0]                grant_idx;
    logic [mem_pkg::PORT_IDX_W-1:0]                rr_q;
    logic [mem_pkg::PORT_IDX_W-1:0]                gnt_idx_q;
    logic                                          rsp_pending_q;

    // ----------------------------------------
    // Per-port request and response wiring
    // ----------------------------------------
    for (genvar p = 0; p < mem_pkg::NUM_PORTS; p++) begin : g_port
        assign valid_vec[p] = ports[p].valid;
        assign req_vec[p]   = ports[p].req;

        assign ports[p].pop       = grant_valid && (grant_idx == mem_pkg::PORT_IDX_W'(p));
        assign ports[p].rsp_valid = rsp_pending_q && (gnt_idx_q == mem_pkg::PORT_IDX_W'(p));
        // Only the port flagged by rsp_valid picks this up
        assign ports[p].rsp_rdata = mem_rdata_i;
    end

    // ----------------------------------------
    // Round-robin pick
    // ----------------------------------------
    // Search starts one past the last granted port
    always_comb begin
        int unsigned cand;
        grant_valid = 1'b0;
        grant_idx   = rr_q;
        for (int unsigned i = 1; i <= mem_pkg::NUM_PORTS; i++) begin
            cand = int'(rr_q) + i;
            if (cand >= mem_pkg::NUM_PORTS) begin
                cand = cand - mem_pkg::NUM_PORTS;
            end
            if (!grant_valid && valid_vec[cand]) begin
                grant_valid = 1'b1;
                grant_idx   = mem_pkg::PORT_IDX_W'(cand);
            end
        end
    end

    assign mem_en_o  = grant_valid;
    assign mem_req_o = req_vec[grant_idx];

    // Remember who was served so the read data goes back one cycle later
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q          <= mem_pkg::PORT_IDX_W'(mem_pkg::NUM_PORTS - 1);
            gnt_idx_q     <= '0;
            rsp_pending_q <= 1'b0;
        end else begin
            rsp_pending_q <= grant_valid;
            if (grant_valid) begin
                rr_q      <= grant_idx;
                gnt_idx_q <= grant_idx;
            end
        end
    end

    assign drained_o = ~(|valid_vec) & ~rsp_pending_q;

endmodule

// ==== word_memory.sv ====
// Shared backing store with byte-enable writes and a registered read port
`timescale 1ns/1ps

module word_memory #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          en_i,
    input  mem_pkg::mem_req_t             req_i,
    output logic [mem_pkg::DATA_W-1:0]    rdata_o
);

    localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    mem_pkg::mem_word_u           mem [MEM_WORDS];
    logic [IDX_W-1:0]             idx;
    mem_pkg::mem_word_u           wdata_u;
    mem_pkg::mem_word_u           merged;
    logic [mem_pkg::DATA_W-1:0]   rdata_q;

    // Word address wraps onto the array
    assign idx = IDX_W'(req_i.addr % MEM_WORDS);

    // Byte-wise merge of the write data into the stored word
    always_comb begin
        wdata_u.word = req_i.wdata;
        merged       = mem[idx];
        for (int b = 0; b < mem_pkg::BE_W; b++) begin
            if (req_i.be[b]) begin
                merged.bytes[b] = wdata_u.bytes[b];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
            rdata_q <= '0;
        end else if (en_i) begin
            if (req_i.we) begin
                mem[idx] <= merged;
                // Merged word doubles as the write acknowledge
                rdata_q  <= merged.word;
            end else begin
                rdata_q  <= mem[idx].word;
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== mem_subsys_top.sv ====
// Top level of the memory subsystem: ingress, per-port queues, arbiter and shared memory
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int unsigned                QUEUE_DEPTH   = 4,
    parameter int unsigned                MEM_WORDS     = 256,
    parameter logic [mem_pkg::ADDR_W-1:0] TOHOST_ADDR   = 32'h0000_1000,
    parameter logic [mem_pkg::ADDR_W-1:0] FROMHOST_ADDR = 32'h0000_1040
) (
    input  logic                                                  clk_i,
    input  logic                                                  rst_ni,
    // Requests, one lane per port
    input  logic [mem_pkg::NUM_PORTS-1:0]                         req_valid_i,
    input  logic [mem_pkg::NUM_PORTS-1:0]                         req_we_i,
    input  logic [mem_pkg::NUM_PORTS-1:0][mem_pkg::ADDR_W-1:0]    req_addr_i,
    input  logic [mem_pkg::NUM_PORTS-1:0][mem_pkg::DATA_W-1:0]    req_wdata_i,
    input  logic [mem_pkg::NUM_PORTS-1:0][mem_pkg::BE_W-1:0]      req_be_i,
    output logic [mem_pkg::NUM_PORTS-1:0]                         credit_o,
    // Responses
    output logic [mem_pkg::NUM_PORTS-1:0]                         rsp_valid_o,
    output logic [mem_pkg::NUM_PORTS-1:0][mem_pkg::DATA_W-1:0]    rsp_rdata_o,
    // Flush
    input  logic                                                  flush_req_i,
    output logic                                                  flushing_o
);

    logic [mem_pkg::NUM_PORTS-1:0]                push;
    mem_pkg::mem_req_t [mem_pkg::NUM_PORTS-1:0]   push_req;
    logic [mem_pkg::NUM_PORTS-1:0]                freed;
    logic                                         drained;

    mem_pkg::mem_req_t                            mem_req;
    logic                                         mem_en;
    logic [mem_pkg::DATA_W-1:0]                   mem_rdata;

    mem_port_if port_if [mem_pkg::NUM_PORTS] ();

    ingress_ctrl #(
        .QUEUE_DEPTH   ( QUEUE_DEPTH   ),
        .TOHOST_ADDR   ( TOHOST_ADDR   ),
        .FROMHOST_ADDR ( FROMHOST_ADDR )
    ) i_ingress_ctrl (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .req_valid_i ( req_valid_i ),
        .req_we_i    ( req_we_i    ),
        .req_addr_i  ( req_addr_i  ),
        .req_wdata_i ( req_wdata_i ),
        .req_be_i    ( req_be_i    ),
        .flush_req_i ( flush_req_i ),
        .freed_i     ( freed       ),
        .drained_i   ( drained     ),
        .push_o      ( push        ),
        .push_req_o  ( push_req    ),
        .credit_o    ( credit_o    ),
        .flushing_o  ( flushing_o  )
    );

    // Instruction, data and bypass queues
    for (genvar p = 0; p < mem_pkg::NUM_PORTS; p++) begin : g_queue
        port_queue #(
            .QUEUE_DEPTH ( QUEUE_DEPTH )
        ) i_port_queue (
            .clk_i       ( clk_i          ),
            .rst_ni      ( rst_ni         ),
            .push_i      ( push[p]        ),
            .push_req_i  ( push_req[p]    ),
            .freed_o     ( freed[p]       ),
            .port        ( port_if[p]     ),
            .rsp_valid_o ( rsp_valid_o[p] ),
            .rsp_rdata_o ( rsp_rdata_o[p] )
        );
    end

    mem_arbiter i_mem_arbiter (
        .clk_i       ( clk_i     ),
        .rst_ni      ( rst_ni    ),
        .ports       ( port_if   ),
        .mem_req_o   ( mem_req   ),
        .mem_en_o    ( mem_en    ),
        .mem_rdata_i ( mem_rdata ),
        .drained_o   ( drained   )
    );

    word_memory #(
        .MEM_WORDS ( MEM_WORDS )
    ) i_word_memory (
        .clk_i   ( clk_i     ),
        .rst_ni  ( rst_ni    ),
        .en_i    ( mem_en    ),
        .req_i   ( mem_req   ),
        .rdata_o ( mem_rdata )
    );

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock and reset source, free-running clock with reset held low for a fixed count
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real         PERIOD_NS    = 4.0,
    parameter int unsigned RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        // Released with the edge so no flop sees a half-released reset
        rst_no <= 1'b1;
    end

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

// ==== tb_mem_subsys.sv ====
// Simulation top that drives random traffic into the memory subsystem and checks a reference model
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int unsigned                QUEUE_DEPTH   = 4;
    localparam int unsigned                MEM_WORDS     = 256;
    localparam logic [mem_pkg::ADDR_W-1:0] TOHOST_ADDR   = 32'h0000_1000;
    localparam logic [mem_pkg::ADDR_W-1:0] FROMHOST_ADDR = 32'h0000_1040;
    localparam int                         NP            = mem_pkg::NUM_PORTS;
    localparam real                        CLK_PERIOD_NS = 4.0;
    localparam int                         RESET_CYCLES  = 16;
    localparam int                         RING          = 16;
    localparam int                         IDLE_LIMIT    = 200;

    // Test sizes that also set the watchdog
    localparam int N_RAW   = 8;
    localparam int N_MIX   = 24;
    localparam int N_FLUSH = 3;
    localparam int TOTAL_REQ = 4 * N_RAW + 3 * N_MIX + QUEUE_DEPTH + 3 * N_FLUSH + 4;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_REQ * 20 + 3 * IDLE_LIMIT;

    logic                                        clk, rst_n;
    logic [NP-1:0]                               req_valid, req_we, credit, rsp_valid;
    logic [NP-1:0][mem_pkg::ADDR_W-1:0]          req_addr;
    logic [NP-1:0][mem_pkg::DATA_W-1:0]          req_wdata, rsp_rdata;
    logic [NP-1:0][mem_pkg::BE_W-1:0]            req_be;
    logic                                        flush_req, flushing, flushing_prev;

    // Requester and memory model state
    int                                          credits [NP];
    int                                          wr_cnt [NP];
    int                                          rd_cnt [NP];
    logic [mem_pkg::DATA_W-1:0]                  exp_buf [NP][RING];
    logic [mem_pkg::DATA_W-1:0]                  model_mem [MEM_WORDS];
    int                                          err_value, err_other;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) i_clk_gen (
        .clk_o  ( clk   ),
        .rst_no ( rst_n )
    );

    mem_subsys_top #(
        .QUEUE_DEPTH   ( QUEUE_DEPTH   ),
        .MEM_WORDS     ( MEM_WORDS     ),
        .TOHOST_ADDR   ( TOHOST_ADDR   ),
        .FROMHOST_ADDR ( FROMHOST_ADDR )
    ) DUT (
        .clk_i       ( clk       ),
        .rst_ni      ( rst_n     ),
        .req_valid_i ( req_valid ),
        .req_we_i    ( req_we    ),
        .req_addr_i  ( req_addr  ),
        .req_wdata_i ( req_wdata ),
        .req_be_i    ( req_be    ),
        .credit_o    ( credit    ),
        .rsp_valid_o ( rsp_valid ),
        .rsp_rdata_o ( rsp_rdata ),
        .flush_req_i ( flush_req ),
        .flushing_o  ( flushing  )
    );

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("** Error @ %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        err_other++;
        $display("Failure @ %0t: %s", $time, what);
    endtask

    // Each port owns its own window of 16 words with random low byte bits
    function automatic logic [mem_pkg::ADDR_W-1:0] rand_addr(input int p);
        int unsigned word;
        word = 32 + 32 * p + $urandom_range(15);
        return mem_pkg::ADDR_W'((word << 3) | $urandom_range(7));
    endfunction

    // Sends one request once a credit is in hand and updates the model at send time
    task automatic send_req(input int p, input logic we, input logic [mem_pkg::ADDR_W-1:0] addr,
                            input logic [mem_pkg::DATA_W-1:0] wdata,
                            input logic [mem_pkg::BE_W-1:0] be);
        int unsigned idx;
        @(posedge clk);
        while (credits[p] == 0) begin
            @(posedge clk);
        end
        req_valid[p] <= 1'b1;
        req_we[p]    <= we;
        req_addr[p]  <= addr;
        req_wdata[p] <= wdata;
        req_be[p]    <= be;
        credits[p]--;
        idx = (addr >> 3) % MEM_WORDS;
        if (we) begin
            for (int b = 0; b < mem_pkg::BE_W; b++) begin
                if (be[b]) begin
                    model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        // Writes answer with the merged word, reads with the stored one
        exp_buf[p][wr_cnt[p] % RING] = model_mem[idx];
        wr_cnt[p]++;
        @(posedge clk);
        req_valid[p] <= 1'b0;
    endtask

    task automatic run_port_traffic(input int p, input int n);
        repeat (n) begin
            repeat ($urandom_range(2)) @(posedge clk);
            send_req(p, 1'($urandom_range(1)), rand_addr(p), {$urandom, $urandom},
                     8'($urandom_range(255)));
        end
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush_req <= 1'b1;
        @(posedge clk);
        flush_req <= 1'b0;
        @(negedge clk);
        check_value("flushing_o", flushing, 1'b1);
    endtask

    task automatic wait_flush_end();
        while (flushing !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    function automatic bit all_home();
        for (int p = 0; p < NP; p++) begin
            if (credits[p] != QUEUE_DEPTH || wr_cnt[p] != rd_cnt[p]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Waits until every credit is back and every response has arrived
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (!all_home() && cycles < IDLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!all_home()) begin
            report_failure("credits or responses still missing after the idle wait");
        end
        for (int p = 0; p < NP; p++) begin
            check_value($sformatf("credit count port %0d", p), credits[p], QUEUE_DEPTH);
        end
    endtask

    // ----------------------------------------
    // Response and credit monitor
    // ----------------------------------------
    always @(negedge clk) begin
        // Requests sent in this very cycle came after the drain
        if (flushing_prev && !flushing) begin
            for (int p = 0; p < NP; p++) begin
                check_value($sformatf("outstanding responses port %0d at flush end", p),
                            wr_cnt[p] - rd_cnt[p] - int'(req_valid[p]), 0);
            end
        end
        flushing_prev = flushing;
        if (flushing && (|credit)) begin
            report_failure("credit_o pulsed while flushing_o was high");
        end
        for (int p = 0; p < NP; p++) begin
            if (rsp_valid[p]) begin
                if (wr_cnt[p] == rd_cnt[p]) begin
                    report_failure($sformatf("response on port %0d with no request pending", p));
                end else begin
                    check_value($sformatf("rsp_rdata_o[%0d]", p), rsp_rdata[p],
                                exp_buf[p][rd_cnt[p] % RING]);
                    rd_cnt[p]++;
                end
            end
            if (credit[p]) begin
                credits[p]++;
                if (credits[p] > QUEUE_DEPTH) begin
                    report_failure($sformatf("port %0d got more credits than queue slots", p));
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
        $display("Test FAILED");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [mem_pkg::ADDR_W-1:0] addrs [N_RAW];
        req_valid = '0;
        req_we    = '0;
        req_addr  = '0;
        req_wdata = '0;
        req_be    = '0;
        flush_req = 1'b0;
        flushing_prev = 1'b0;
        err_value = 0;
        err_other = 0;
        for (int p = 0; p < NP; p++) begin
            credits[p] = QUEUE_DEPTH;
            wr_cnt[p]  = 0;
            rd_cnt[p]  = 0;
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            model_mem[w] = '0;
        end
        void'($urandom(32'hfae9_77a1));
        wait (rst_n === 1'b1);

        // Read after write on the instruction port with full byte enables
        for (int i = 0; i < N_RAW; i++) begin
            addrs[i] = rand_addr(0);
            send_req(0, 1'b1, addrs[i], {$urandom, $urandom}, 8'hff);
        end
        for (int i = 0; i < N_RAW; i++) begin
            send_req(0, 1'b0, addrs[i], '0, '0);
        end
        wait_idle();

        // Byte-enable merge on the data port
        for (int i = 0; i < N_RAW; i++) begin
            addrs[i] = rand_addr(1);
            send_req(1, 1'b1, addrs[i], {$urandom, $urandom}, 8'($urandom_range(255)));
        end
        for (int i = 0; i < N_RAW; i++) begin
            send_req(1, 1'b0, addrs[i], '0, '0);
        end
        wait_idle();

        // All ports at once with more offered load than the memory can serve
        fork
            run_port_traffic(0, N_MIX);
            run_port_traffic(1, N_MIX);
            run_port_traffic(2, N_MIX);
        join
        wait_idle();

        // One full queue worth of requests before every credit comes back
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            send_req(2, 1'b0, rand_addr(2), '0, '0);
        end
        wait_idle();

        // Flush by request with traffic in flight
        fork
            run_port_traffic(0, N_FLUSH);
            run_port_traffic(1, N_FLUSH);
            run_port_traffic(2, N_FLUSH);
            begin
                repeat (2) @(posedge clk);
                pulse_flush();
            end
        join
        wait_flush_end();
        wait_idle();

        // Mailbox stores flush while mailbox loads do not
        send_req(1, 1'b1, TOHOST_ADDR, {$urandom, $urandom}, 8'hff);
        @(negedge clk);
        check_value("flushing_o", flushing, 1'b1);
        wait_flush_end();
        wait_idle();
        send_req(2, 1'b1, FROMHOST_ADDR, {$urandom, $urandom}, 8'hff);
        @(negedge clk);
        check_value("flushing_o", flushing, 1'b1);
        wait_flush_end();
        wait_idle();
        send_req(0, 1'b0, TOHOST_ADDR, '0, '0);
        @(negedge clk);
        check_value("flushing_o", flushing, 1'b0);
        send_req(0, 1'b0, FROMHOST_ADDR, '0, '0);
        @(negedge clk);
        check_value("flushing_o", flushing, 1'b0);
        wait_idle();

        $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
mem_pkg.sv
mem_port_if.sv
ingress_ctrl.sv
port_queue.sv
mem_arbiter.sv
word_memory.sv
mem_subsys_top.sv
tb_clk_gen.sv
tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - mem_pkg.sv
  - mem_port_if.sv
  - ingress_ctrl.sv
  - port_queue.sv
  - mem_arbiter.sv
  - word_memory.sv
  - mem_subsys_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_mem_subsys.sv
